// File: atom_core.f
src/atom_bus_pkg.sv
src/atom_io_pkg.sv
src/clken_gen.sv
src/cas_tone_gen.sv
src/pia_8255.sv
src/atom_mem_map.sv
src/atom_core.sv
verif/atom_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= atom_core_tb
FILELIST  ?= atom_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/atom_core_tb.sv
// Plays the 6502 side with CLKDIV_BITS 3 and CAS_DIV 4; the bus changes only after an enable
`default_nettype none
`timescale 1ns/1ns

module atom_core_tb
   import atom_bus_pkg::*;
   import atom_io_pkg::*;
();

   // ======================================================================
   // Parameters and signals
   // ======================================================================

   localparam int CLKDIV_BITS   = 3;
   localparam int CAS_DIV       = 4;
   localparam int CLKEN_PERIOD  = 1 << CLKDIV_BITS;
   localparam int CLKEN_TIMEOUT = 4 * CLKEN_PERIOD;
   localparam int CLK_HALF      = 10;
   localparam int DRIVE_DELAY   = 2;
   localparam int NUM_TRANS     = 600;
   localparam logic [31:0] LFSR_SEED = 32'h7cd2;
   // x^32 + x^22 + x^2 + x + 1
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

   logic          clk64 = 1'b0;
   logic          reset;
   atom_bus_req_t bus;
   atom_kbd_in_t  kbd;
   logic          cas_in;
   logic [15:0]   ram_rdata;
   logic          cpu_clken;
   logic [7:0]    cpu_din;
   atom_ram_req_t ram_req;
   logic [7:0]    pia_pa;
   logic          cas_out;

   // Reference model state
   logic [7:0]  m_pa;
   logic [3:0]  m_pc;
   logic [7:0]  m_latch;
   logic        m_tone;
   int          m_en_cnt;

   logic [31:0] lfsr_state = LFSR_SEED;
   // Falling edges seen since reset went low
   int          edge_cnt;

   atom_core #(
      .CLKDIV_BITS(CLKDIV_BITS),
      .CAS_DIV    (CAS_DIV)
   ) dut_i (
      .clk64    (clk64),
      .reset    (reset),
      .bus      (bus),
      .kbd      (kbd),
      .cas_in   (cas_in),
      .ram_rdata(ram_rdata),
      .cpu_clken(cpu_clken),
      .cpu_din  (cpu_din),
      .ram_req  (ram_req),
      .pia_pa   (pia_pa),
      .cas_out  (cas_out)
   );

   // 20 ns clock
   always #CLK_HALF clk64 = ~clk64;

   // ======================================================================
   // Failure reporting and compare tasks
   // ======================================================================

   task automatic fail_run(string msg);
      $display("%s", msg);
      $display("Verification failed");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   task automatic check_byte(logic [7:0] got, logic [7:0] exp, string what);
      if (got !== exp)
         fail_run($sformatf("ERR %0t: %s got %02h expected %02h", $time, what, got, exp));
   endtask

   task automatic check_bit(logic got, logic exp, string what);
      if (got !== exp)
         fail_run($sformatf("ERR %0t: %s got %b expected %b", $time, what, got, exp));
   endtask

   task automatic check_ram_req(atom_ram_req_t got, atom_ram_req_t exp);
      string got_s;
      string exp_s;
      got_s = $sformatf("addr %05h we %b oe %b wdata %04h",
                        got.addr, got.we, got.oe, got.wdata);
      exp_s = $sformatf("addr %05h we %b oe %b wdata %04h",
                        exp.addr, exp.we, exp.oe, exp.wdata);
      if (got !== exp)
         fail_run($sformatf("ERR %0t: ram_req got %s, expected %s", $time, got_s, exp_s));
   endtask

   // ======================================================================
   // Random source
   // ======================================================================

   function automatic logic [31:0] lfsr_step(logic [31:0] s);
      return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] take_bits(int n);
      logic [31:0] val;
      int          i;
      val = '0;
      for (i = 0; i < n; i++)
      begin
         val        = {val[30:0], lfsr_state[0]};
         lfsr_state = lfsr_step(lfsr_state);
      end
      return val;
   endfunction

   // ======================================================================
   // Reference model
   // ======================================================================

   // Decode priority as in the Atom memory map
   function automatic atom_region_e exp_region(logic [15:0] a, logic [7:0] lat);
      if (a == 16'hBFFF)
         return REG_LATCH;
      if (a[15:4] == 12'hB00)
         return REG_PIA;
      if ((a[15:4] == 12'hB40) || (a[15:4] == 12'hB80) || (a[15:4] == 12'hBC0) ||
          (a[15:8] == 8'hBD))
         return REG_NULL;
      if (a[15:12] >= 4'hC)
         return REG_ROM;
      // Bank 7 puts RAM in the A window
      if ((a[15:12] == 4'hA) && (lat[2:0] != 3'b111))
         return REG_ROM;
      return REG_RAM;
   endfunction

   function automatic logic [7:0] exp_din();
      logic [7:0] d;
      case (exp_region(bus.addr, m_latch))
         REG_PIA:
            case (pia_reg_e'(bus.addr[1:0]))
               PIA_PA:
                  d = m_pa;
               PIA_PB:
                  d = {kbd.shift_n, kbd.ctrl_n, kbd.keyout};
               PIA_PC:
                  d = {kbd.fs_n, kbd.rept_n, cas_in, m_tone, m_pc};
               default:
                  d = 8'h00;
            endcase
         REG_NULL:
            d = 8'h00;
         REG_LATCH:
            d = m_latch;
         default:
            d = bus.addr[0] ? ram_rdata[15:8] : ram_rdata[7:0];
      endcase
      return d;
   endfunction

   // Strobes idle in the enable cycle
   function automatic atom_ram_req_t exp_ram_req(logic in_enable);
      atom_ram_req_t r;
      r.addr  = (bus.addr[15:12] == 4'hA) ? {3'b010, m_latch[2:0], bus.addr[11:0]}
                                          : {2'b00, bus.addr};
      r.we    = !in_enable && !bus.rnw && (exp_region(bus.addr, m_latch) != REG_ROM);
      r.oe    = !in_enable && bus.rnw;
      r.wdata = {bus.wdata, bus.wdata};
      return r;
   endfunction

   // Cassette line high when PC0 is low or when PC1 gates a low tone
   function automatic logic exp_cas_out();
      logic o;
      o = 1'b0;
      if (!m_pc[0])
         o = 1'b1;
      else if (m_pc[1] && !m_tone)
         o = 1'b1;
      return o;
   endfunction

   // Effect of the edge that closes an enable cycle
   task automatic apply_enable();
      m_en_cnt++;
      if (m_en_cnt == CAS_DIV)
      begin
         m_en_cnt = 0;
         m_tone   = ~m_tone;
      end
      if (!bus.rnw)
      begin
         if (bus.addr == 16'hBFFF)
            m_latch = bus.wdata;
         else if (bus.addr[15:4] == 12'hB00)
         begin
            case (pia_reg_e'(bus.addr[1:0]))
               PIA_PA:
                  m_pa = bus.wdata;
               PIA_PC:
                  m_pc = bus.wdata[3:0];
               PIA_CTRL:
                  // Bit set/reset word
                  if (!bus.wdata[7])
                     m_pc[bus.wdata[2:1]] = bus.wdata[0];
               default:
                  ;
            endcase
         end
      end
   endtask

   // ======================================================================
   // Stimulus and sampling
   // ======================================================================

   task automatic drive_random();
      logic [15:0] a;
      logic [7:0]  off;
      case (3'(take_bits(3)))
         // PIA twice as often
         3'd0, 3'd1:
            a = {12'hB00, 4'(take_bits(4))};
         3'd2:
            a = 16'hBFFF;
         3'd3:
            a = {4'hA, 12'(take_bits(12))};
         3'd4:
            a = {2'b11, 14'(take_bits(14))};
         3'd5:
         begin
            off = 8'(take_bits(8));
            case (2'(take_bits(2)))
               2'd0:
                  a = {12'hB40, off[3:0]};
               2'd1:
                  a = {12'hB80, off[3:0]};
               2'd2:
                  a = {12'hBC0, off[3:0]};
               default:
                  a = {8'hBD, off};
            endcase
         end
         // Plain RAM below 8000
         default:
            a = {1'b0, 15'(take_bits(15))};
      endcase
      bus.addr  = a;
      bus.rnw   = 1'(take_bits(1));
      bus.wdata = 8'(take_bits(8));
      kbd       = atom_kbd_in_t'(10'(take_bits(10)));
      cas_in    = 1'(take_bits(1));
      ram_rdata = 16'(take_bits(16));
   endtask

   task automatic check_cycle(logic in_enable);
      check_byte(cpu_din, exp_din(), $sformatf("cpu_din at %04h", bus.addr));
      check_byte(pia_pa, m_pa, "pia_pa");
      check_ram_req(ram_req, exp_ram_req(in_enable));
      check_bit(cas_out, exp_cas_out(), "cas_out");
   endtask

   // Returns on the falling edge inside the enable cycle
   task automatic wait_clken();
      int n;
      n = 0;
      while (!cpu_clken)
      begin
         if (n == CLKEN_TIMEOUT)
            fail_run($sformatf("Timeout: no cpu_clken pulse within %0d cycles", CLKEN_TIMEOUT));
         @(negedge clk64);
         n++;
      end
   endtask

   // Enable spacing, and idle strobes while in reset
   always @(negedge clk64)
   begin
      if (reset)
      begin
         edge_cnt = 0;
         check_bit(cpu_clken, 1'b0, "cpu_clken in reset");
         check_bit(ram_req.we, 1'b0, "ram_req.we in reset");
         check_bit(ram_req.oe, 1'b0, "ram_req.oe in reset");
      end
      else
      begin
         // First pulse follows the first rising edge out of reset
         check_bit(cpu_clken, (edge_cnt % CLKEN_PERIOD) == 1, "cpu_clken");
         edge_cnt++;
      end
   end

   // ======================================================================
   // Main sequence
   // ======================================================================

   initial
   begin
      reset     = 1'b1;
      bus       = '0;
      bus.rnw   = 1'b1;
      kbd       = '1;
      cas_in    = 1'b0;
      ram_rdata = 16'h0000;
      m_pa      = 8'h00;
      m_pc      = 4'h0;
      m_latch   = 8'h00;
      m_tone    = 1'b0;
      m_en_cnt  = 0;
      // Read request for the first half of reset
      repeat (5) @(posedge clk64);
      #DRIVE_DELAY;
      // Then a RAM write request until reset falls
      bus.rnw = 1'b0;
      repeat (5) @(posedge clk64);
      #DRIVE_DELAY;
      reset = 1'b0;
      for (int t = 0; t < NUM_TRANS; t++)
      begin
         // Between enables
         @(negedge clk64);
         check_cycle(1'b0);
         wait_clken();
         check_cycle(1'b1);
         apply_enable();
         // New request in the cycle after the pulse
         @(posedge clk64);
         #DRIVE_DELAY;
         drive_random();
      end
      $display("Verification passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: src/atom_core.sv
// Atom system-control core; the CPU, keyboard and RAM device sit outside and follow cpu_clken
`default_nettype none
`timescale 1ns/1ns

module atom_core
   import atom_bus_pkg::*;
   import atom_io_pkg::*;
#(
   parameter int CLKDIV_BITS = 7,
   parameter int CAS_DIV     = 208
) (
   input  wire logic          clk64,
   input  wire logic          reset,
   input  wire atom_bus_req_t bus,
   input  wire atom_kbd_in_t  kbd,
   input  wire logic          cas_in,
   input  wire logic [15:0]   ram_rdata,
   output logic               cpu_clken,
   output logic [7:0]         cpu_din,
   output atom_ram_req_t      ram_req,
   output logic [7:0]         pia_pa,
   output logic               cas_out
);

   // ======================================================================
   // Internal nets
   // ======================================================================

   logic [7:0] pia_dout;
   logic [3:0] pc_low;
   logic       cas_tone;
   logic       pia_sel;

   // CPU cycle timing
   clken_gen #(
      .CLKDIV_BITS(CLKDIV_BITS)
   ) clken_gen_i (
      .clk64    (clk64),
      .reset    (reset),
      .cpu_clken(cpu_clken)
   );

   // Cassette output tone
   cas_tone_gen #(
      .CAS_DIV(CAS_DIV)
   ) cas_tone_gen_i (
      .clk64    (clk64),
      .reset    (reset),
      .cpu_clken(cpu_clken),
      .pc_low   (pc_low),
      .cas_tone (cas_tone),
      .cas_out  (cas_out)
   );

   // Keyboard and cassette port
   pia_8255 pia_8255_i (
      .clk64    (clk64),
      .reset    (reset),
      .cpu_clken(cpu_clken),
      .bus      (bus),
      .pia_sel  (pia_sel),
      .kbd      (kbd),
      .cas_in   (cas_in),
      .cas_tone (cas_tone),
      .pia_dout (pia_dout),
      .pia_pa   (pia_pa),
      .pc_low   (pc_low)
   );

   // Decode, banking and read path
   atom_mem_map atom_mem_map_i (
      .clk64    (clk64),
      .reset    (reset),
      .cpu_clken(cpu_clken),
      .bus      (bus),
      .pia_dout (pia_dout),
      .ram_rdata(ram_rdata),
      .pia_sel  (pia_sel),
      .ram_req  (ram_req),
      .cpu_din  (cpu_din)
   );

endmodule

`default_nettype wire

// File: src/atom_mem_map.sv
// Atom address decode and read mux; external RAM accesses are only valid between CPU enables
`default_nettype none
`timescale 1ns/1ns

module atom_mem_map
   import atom_bus_pkg::*;
(
   input  wire logic          clk64,
   input  wire logic          reset,
   input  wire logic          cpu_clken,
   input  wire atom_bus_req_t bus,
   input  wire logic [7:0]    pia_dout,
   input  wire logic [15:0]   ram_rdata,
   output logic               pia_sel,
   output atom_ram_req_t      ram_req,
   output logic [7:0]         cpu_din
);

   atom_region_e region;
   logic [7:0]   rom_latch;
   logic         bank_sel;

   // Axxx window, RAM or ROM depending on the latch
   assign bank_sel = (bus.addr[15:12] == BANK_NIBBLE);

   // ======================================================================
   // Region decode
   // ======================================================================

   always_comb
   begin
      region = REG_RAM;
      if (bus.addr == ROM_LATCH_ADDR)
         region = REG_LATCH;
      else if (bus.addr[15:4] == PIA_PAGE)
         region = REG_PIA;
      // Unfitted peripherals
      else if ((bus.addr[15:4] == NULL_PAGE_B40) || (bus.addr[15:4] == NULL_PAGE_B80) ||
               (bus.addr[15:4] == NULL_PAGE_BC0) || (bus.addr[15:8] == NULL_BLOCK_BD))
         region = REG_NULL;
      // C000-FFFF always ROM, Axxx unless bank 7 is selected
      else if ((bus.addr[15:14] == 2'b11) || (bank_sel && (rom_latch[2:0] != 3'b111)))
         region = REG_ROM;
   end

   assign pia_sel = (region == REG_PIA);

   // ======================================================================
   // ROM bank latch at BFFF
   // ======================================================================

   always_ff @(posedge clk64 or posedge reset)
   begin
      if (reset)
         rom_latch <= 8'h00;
      else if (cpu_clken && (region == REG_LATCH) && !bus.rnw)
         rom_latch <= bus.wdata;
   end

   // ======================================================================
   // External RAM request
   // ======================================================================

   // Axxx maps to one of eight 4 KB banks above 64 KB
   assign ram_req.addr  = bank_sel ? {3'b010, rom_latch[2:0], bus.addr[11:0]} :
                                     {2'b00, bus.addr};
   // Strobes idle in the enable cycle, when the CPU moves on
   // ROM regions are write protected
   // Nothing reaches the RAM while the system is held in reset
   assign ram_req.we    = ~reset & ~cpu_clken & ~bus.rnw & (region != REG_ROM);
   assign ram_req.oe    = ~reset & ~cpu_clken & bus.rnw;
   // Byte lane picked by the RAM from addr bit 0
   assign ram_req.wdata = {bus.wdata, bus.wdata};

   // ======================================================================
   // CPU read data
   // ======================================================================

   always_comb
   begin
      case (region)
         REG_PIA:
            cpu_din = pia_dout;
         REG_NULL:
            cpu_din = 8'h00;
         REG_LATCH:
            cpu_din = rom_latch;
         default:
            cpu_din = bus.addr[0] ? ram_rdata[15:8] : ram_rdata[7:0];
      endcase
   end

   // Bank changes only follow a CPU write to BFFF
   a_latch_write : assert property (@(posedge clk64) disable iff (reset)
      $changed(rom_latch) |-> $past(cpu_clken && !bus.rnw && (bus.addr == ROM_LATCH_ADDR)))
      else $error("ROM latch changed without a write to BFFF");

endmodule

`default_nettype wire

// File: src/pia_8255.sv
// Fixed-direction 8255: PA out, PB in, PC low out and PC high in; control word mode set is ignored
`default_nettype none
`timescale 1ns/1ns

module pia_8255
   import atom_bus_pkg::*;
   import atom_io_pkg::*;
(
   input  wire logic          clk64,
   input  wire logic          reset,
   input  wire logic          cpu_clken,
   input  wire atom_bus_req_t bus,
   input  wire logic          pia_sel,
   input  wire atom_kbd_in_t  kbd,
   input  wire logic          cas_in,
   input  wire logic          cas_tone,
   output logic [7:0]         pia_dout,
   output logic [7:0]         pia_pa,
   output logic [3:0]         pc_low
);

   // Output latches
   logic [7:0] pa_r;
   logic [3:0] pc_r;

   // Register addressed by the CPU
   pia_reg_e   reg_sel;
   logic       wr_en;

   assign reg_sel = pia_reg_e'(bus.addr[1:0]);
   assign wr_en   = cpu_clken & pia_sel & ~bus.rnw;

   // ======================================================================
   // Register writes
   // ======================================================================

   always_ff @(posedge clk64 or posedge reset)
   begin
      if (reset)
      begin
         pa_r <= 8'h00;
         pc_r <= 4'h0;
      end
      else if (wr_en)
      begin
         case (reg_sel)
            PIA_PA:
               pa_r <= bus.wdata;
            PIA_PC:
               pc_r <= bus.wdata[3:0];
            PIA_CTRL:
               // Bit set/reset form only
               if (!bus.wdata[7])
                  pc_r[bus.wdata[2:1]] <= bus.wdata[0];
            default:
               ;
         endcase
      end
   end

   // ======================================================================
   // Read mux
   // ======================================================================

   always_comb
   begin
      case (reg_sel)
         PIA_PA:
            pia_dout = pa_r;
         PIA_PB:
            pia_dout = {kbd.shift_n, kbd.ctrl_n, kbd.keyout};
         PIA_PC:
            // Upper nibble is live status
            pia_dout = {kbd.fs_n, kbd.rept_n, cas_in, cas_tone, pc_r};
         default:
            pia_dout = 8'h00;
      endcase
   end

   assign pia_pa = pa_r;
   assign pc_low = pc_r;

   // Latches only move on the edge that closes a CPU cycle
   a_pia_write_timing : assert property (@(posedge clk64) disable iff (reset)
      $changed({pa_r, pc_r}) |-> $past(cpu_clken))
      else $error("PIA register changed outside a CPU enable");

endmodule

`default_nettype wire

// File: src/cas_tone_gen.sv
// Cassette tone toggles every CAS_DIV CPU enables; pc_low bits 3:2 do not reach the gating
`default_nettype none
`timescale 1ns/1ns

module cas_tone_gen #(
   parameter int CAS_DIV = 208
) (
   input  wire logic       clk64,
   input  wire logic       reset,
   input  wire logic       cpu_clken,
   input  wire logic [3:0] pc_low,
   output logic            cas_tone,
   output logic            cas_out
);

   localparam int CNT_W = (CAS_DIV > 1) ? $clog2(CAS_DIV) : 1;

   // Enable count within one half period
   logic [CNT_W-1:0] tone_cnt;

   // ======================================================================
   // Tone divider
   // ======================================================================

   always_ff @(posedge clk64 or posedge reset)
   begin
      if (reset)
      begin
         tone_cnt <= '0;
         cas_tone <= 1'b0;
      end
      else if (cpu_clken)
      begin
         // Last enable of the half period
         if (tone_cnt == CNT_W'(CAS_DIV - 1))
         begin
            tone_cnt <= '0;
            cas_tone <= ~cas_tone;
         end
         else
            tone_cnt <= tone_cnt + CNT_W'(1);
      end
   end

   // ======================================================================
   // Output gating
   // ======================================================================

   // PC0 low forces the line high
   // PC1 high lets the inverted tone through
   assign cas_out = ~pc_low[0] | (pc_low[1] & ~cas_tone);

endmodule

`default_nettype wire

// File: src/clken_gen.sv
// CPU enable every 2**CLKDIV_BITS cycles of clk64; first pulse one cycle after reset falls
`default_nettype none
`timescale 1ns/1ns

module clken_gen #(
   parameter int CLKDIV_BITS = 7
) (
   input  wire logic clk64,
   input  wire logic reset,
   output logic      cpu_clken
);

   // Free-running divider
   logic [CLKDIV_BITS-1:0] div_cnt;

   always_ff @(posedge clk64 or posedge reset)
   begin
      if (reset)
      begin
         div_cnt   <= '0;
         cpu_clken <= 1'b0;
      end
      else
      begin
         div_cnt   <= div_cnt + CLKDIV_BITS'(1);
         // Registered so the enable is glitch free
         cpu_clken <= (div_cnt == '0);
      end
   end

   // Enable is a single-cycle pulse
   a_clken_single : assert property (@(posedge clk64) disable iff (reset)
      cpu_clken |=> !cpu_clken)
      else $error("cpu_clken high on two adjacent cycles");

endmodule

`default_nettype wire

// File: src/atom_io_pkg.sv
// PIA register codes and keyboard/status inputs; all keyboard lines are active low from outside
`default_nettype none

package atom_io_pkg;

   // ======================================================================
   // 8255 register select, from address bits 1:0
   // ======================================================================

   typedef enum logic [1:0] {
      PIA_PA   = 2'd0,
      PIA_PB   = 2'd1,
      PIA_PC   = 2'd2,
      PIA_CTRL = 2'd3
   } pia_reg_e;

   // ======================================================================
   // Inputs seen on ports B and C
   // ======================================================================

   // Keyboard matrix column data for the row on PA[3:0]
   // Modifier and repeat keys
   // Field sync from the video side
   typedef struct packed {
      logic [5:0] keyout;
      logic       shift_n;
      logic       ctrl_n;
      logic       rept_n;
      logic       fs_n;
   } atom_kbd_in_t;

endpackage

`default_nettype wire

// File: src/atom_bus_pkg.sv
// CPU bus types and Atom memory map; decode assumes a 64 KB 6502 space and 256 KB external RAM
`default_nettype none

package atom_bus_pkg;

   // ======================================================================
   // Address map
   // ======================================================================

   // ROM bank latch, one byte at the top of the B page
   localparam logic [15:0] ROM_LATCH_ADDR = 16'hBFFF;

   // 8255 PIA, 16 bytes at B000
   localparam logic [11:0] PIA_PAGE = 12'hB00;

   // Regions with no device behind them, read back as zero
   localparam logic [11:0] NULL_PAGE_B40 = 12'hB40;
   localparam logic [11:0] NULL_PAGE_B80 = 12'hB80;
   localparam logic [11:0] NULL_PAGE_BC0 = 12'hBC0;
   localparam logic [7:0]  NULL_BLOCK_BD = 8'hBD;

   // Banked 4 KB window at A000
   localparam logic [3:0]  BANK_NIBBLE = 4'hA;

   // ======================================================================
   // Bus types
   // ======================================================================

   // Request from the CPU, held stable between enables
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  wdata;
      logic        rnw;
   } atom_bus_req_t;

   // Decoded target of the current address
   typedef enum logic [2:0] {
      REG_RAM   = 3'd0,
      REG_PIA   = 3'd1,
      REG_NULL  = 3'd2,
      REG_LATCH = 3'd3,
      REG_ROM   = 3'd4
   } atom_region_e;

   // Request to the external 16-bit RAM
   // Write byte appears on both lanes
   typedef struct packed {
      logic [17:0] addr;
      logic        we;
      logic        oe;
      logic [15:0] wdata;
   } atom_ram_req_t;

endpackage

`default_nettype wire
